//--- testbench/tracker_input.txt
# bg   fg   x0 y0 x1 y1 ch lo hi ex ey due gaps   (all hex, rectangle corners inclusive)
# ch 0 r, 1 g, 2 b, 3 y, 4 cr, 5 cb; due 1 when the frame must report a centre
# red rectangle on black, channel r
0000 f800 04 03 0b 08 0 c f 07 05 1 0
# same frame with random idle beats
0000 f800 04 03 0b 08 0 c f 07 05 1 1
# channel cr picks red, black sits at cr nibble 8
0000 f800 0a 05 13 0e 4 c f 0e 09 1 0
# green on black under channel r, nothing masked
0000 07e0 06 06 0c 0c 0 c f 00 00 0 0
# single red pixel
0000 f800 1d 15 1d 15 0 c f 1d 15 1 1
# blue fills the frame, channel b
0000 001f 00 00 1f 17 2 c f 0f 0b 1 1

//--- sources.f
verilog/tracker_pkg.sv
verilog/color_convert.sv
verilog/color_threshold.sv
verilog/serial_divider.sv
verilog/center_of_mass.sv
verilog/blob_tracker.sv
testbench/tracker_checker.sv
testbench/tb_blob_tracker.sv

//--- testbench/tb_blob_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_blob_tracker import tracker_pkg::*; ;

  localparam int H_ACT = 32; // short frames
  localparam int V_ACT = 24;
  localparam int MAX_FRAMES = 32;

  // one line of the data file
  typedef struct packed {
    rgb565_t        bg;
    rgb565_t        fg;
    hcount_t        x0;
    vcount_t        y0;
    hcount_t        x1;
    vcount_t        y1;
    threshold_cfg_t cfg;
    com_t           exp;
    logic           due;  // centre expected for this frame
    logic           gaps; // random idle beats between pixels
  } frame_t;

  logic           clk_65mhz;
  logic           sys_rst;
  pixel_beat_t    pix_in;
  threshold_cfg_t cfg;
  com_t           com;
  logic           com_valid;

  logic exp_push;
  logic exp_due;
  com_t exp_com;
  int   pending;
  int   errors;

  frame_t frames [MAX_FRAMES];
  int     nframes = 0;
  int     cycles = 0;
  int     cycle_limit = 0; // 0 until the data file is read

  blob_tracker #(
    .H_ACTIVE (H_ACT),
    .V_ACTIVE (V_ACT)
  ) dut0 (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .pix_in    (pix_in),
    .cfg       (cfg),
    .com       (com),
    .com_valid (com_valid)
  );

  tracker_checker checker0 (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .com       (com),
    .com_valid (com_valid),
    .exp_push  (exp_push),
    .exp_due   (exp_due),
    .exp_com   (exp_com),
    .pending   (pending),
    .errors    (errors)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #4 clk_65mhz = ~clk_65mhz; // 8 ns period
  end

  // run guard, limit set from the frame count
  always @(posedge clk_65mhz) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: no centre reported in time");
      $display("errors: %0d", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // lines that do not parse as 13 hex fields are comments
  task automatic load_frames();
    int              fd;
    int              ok;
    int              c [12];
    logic [8*128-1:0] line;
    fd = $fopen("testbench/tracker_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && nframes < MAX_FRAMES) begin
        ok = $fgets(line, fd);
        if (ok > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
            c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10],
            c[11], ok) == 13) begin
          frames[nframes].bg          = rgb565_t'(c[0]);
          frames[nframes].fg          = rgb565_t'(c[1]);
          frames[nframes].x0          = hcount_t'(c[2]);
          frames[nframes].y0          = vcount_t'(c[3]);
          frames[nframes].x1          = hcount_t'(c[4]);
          frames[nframes].y1          = vcount_t'(c[5]);
          frames[nframes].cfg.channel = channel_sel_t'(c[6][2:0]);
          frames[nframes].cfg.lower   = nibble_t'(c[7]);
          frames[nframes].cfg.upper   = nibble_t'(c[8]);
          frames[nframes].exp.x       = hcount_t'(c[9]);
          frames[nframes].exp.y       = vcount_t'(c[10]);
          frames[nframes].due         = c[11][0];
          frames[nframes].gaps        = ok[0]; // 13th field
          nframes++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_beat(input logic valid, input int h, input int v, input rgb565_t rgb);
    pixel_beat_t beat;
    beat.valid  = valid;
    beat.hcount = hcount_t'(h);
    beat.vcount = vcount_t'(v);
    beat.rgb    = rgb;
    @(posedge clk_65mhz);
    pix_in <= beat;
  endtask

  // raster order, rectangle corners inclusive
  task automatic send_frame(input frame_t f);
    logic in_rect;
    for (int v = 0; v < V_ACT; v++) begin
      for (int h = 0; h < H_ACT; h++) begin
        in_rect = (h >= f.x0) && (h <= f.x1) && (v >= f.y0) && (v <= f.y1);
        if (f.gaps && ($urandom % 3 == 0)) drive_beat(1'b0, 0, 0, '0); // one idle beat
        drive_beat(1'b1, h, v, in_rect ? f.fg : f.bg);
      end
    end
  endtask

  // idle until the tail leaves the convert pipe, then hand over the expectation
  task automatic close_frame(input frame_t f);
    drive_beat(1'b0, 0, 0, '0);
    @(posedge clk_65mhz);
    exp_push <= 1'b1;
    exp_due  <= f.due;
    exp_com  <= f.exp;
    @(posedge clk_65mhz);
    exp_push <= 1'b0;
    repeat (CONVERT_LATENCY + 1) @(posedge clk_65mhz);
  endtask

  initial begin : main
    sys_rst  = 1'b1;
    pix_in   = '0;
    cfg      = '0;
    exp_push = 1'b0;
    exp_due  = 1'b0;
    exp_com  = '0;
    void'($urandom(32'h6116cd2e));
    load_frames();
    if (nframes == 0) begin
      $display("no test frames read from testbench/tracker_input.txt");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      // worst case every pixel doubled, plus slack per frame and the closing pixel
      cycle_limit = (nframes + 1) * (H_ACT * V_ACT * 2 + 100);
      repeat (3) @(posedge clk_65mhz);
      sys_rst <= 1'b0;
      for (int i = 0; i < nframes; i++) begin
        @(posedge clk_65mhz);
        cfg <= frames[i].cfg; // only between frames
        send_frame(frames[i]);
        close_frame(frames[i]);
      end
      drive_beat(1'b1, 0, 0, '0); // closes the last frame
      drive_beat(1'b0, 0, 0, '0);
      while (pending != 0) @(posedge clk_65mhz);
      repeat (60) @(posedge clk_65mhz); // room for a stray pulse
      $display("errors: %0d", errors);
      if (errors == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tracker_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tracker_checker import tracker_pkg::*; (
  input  wire  clk_65mhz,
  input  wire  sys_rst,
  input  wire  com_t com,
  input  wire  com_valid,
  input  wire  exp_push,   // driver just closed a frame
  input  wire  exp_due,    // that frame should report a centre
  input  wire  com_t exp_com,
  output int   pending,    // centres still owed by the DUT
  output int   errors
);

  com_t exp_q [$]; // oldest frame first

  always @(posedge clk_65mhz) begin : compare
    int   n_err;
    com_t want;
    n_err = errors;
    if (!sys_rst) begin
      // com is registered before com_valid rises, so both are stable here
      if (com_valid) begin
        if (exp_q.size() == 0) begin
          $display("unexpected com_valid pulse with no centre due (com %h)", com);
          n_err++;
        end else begin
          want = exp_q.pop_front();
          if (com.x !== want.x) begin
            $display("Fail com.x expected %h got %h", want.x, com.x);
            n_err++;
          end
          if (com.y !== want.y) begin
            $display("Fail com.y expected %h got %h", want.y, com.y);
            n_err++;
          end
        end
      end
      // older centre should have landed early in the frame just closed
      if (exp_push) begin
        if (exp_q.size() != 0) begin
          $display("missing com_valid pulse, an earlier frame never reported its centre");
          n_err++;
          exp_q.delete();
        end
        if (exp_due) exp_q.push_back(exp_com);
      end
    end
    errors  <= n_err;
    pending <= exp_q.size();
  end

endmodule

`default_nettype wire

//--- verilog/blob_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module blob_tracker import tracker_pkg::*; #(
  parameter int H_ACTIVE  = 320,
  parameter int V_ACTIVE  = 240,
  parameter int DIV_WIDTH = $bits(sum_t)
) (
  input  wire  clk_65mhz,
  input  wire  sys_rst,
  input  wire  pixel_beat_t pix_in,
  input  wire  threshold_cfg_t cfg,
  output com_t com,
  output logic com_valid
);

  ycrcb_t  ycrcb;      // converted pixel
  rgb565_t rgb_conv;   // original rgb, aligned with ycrcb
  logic    valid_conv; // valid, aligned with ycrcb
  logic    mask;

  // coordinates wait out the conversion latency
  hcount_t hcount_pipe [CONVERT_LATENCY];
  vcount_t vcount_pipe [CONVERT_LATENCY];

  always_ff @(posedge clk_65mhz) begin
    hcount_pipe[0] <= pix_in.hcount;
    vcount_pipe[0] <= pix_in.vcount;
    for (int i = 1; i < CONVERT_LATENCY; i++) begin
      hcount_pipe[i] <= hcount_pipe[i-1];
      vcount_pipe[i] <= vcount_pipe[i-1];
    end
  end

  // 3 cycle latency
  color_convert convert_m (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .rgb_in    (pix_in.rgb),
    .valid_in  (pix_in.valid),
    .ycrcb_out (ycrcb),
    .rgb_out   (rgb_conv),
    .valid_out (valid_conv)
  );

  // 0 cycle latency
  color_threshold threshold_m (
    .ycrcb_in (ycrcb),
    .rgb_in   (rgb_conv),
    .valid_in (valid_conv),
    .cfg      (cfg),
    .mask     (mask)
  );

  // variable latency, ends with com_valid
  center_of_mass #(
    .H_ACTIVE  (H_ACTIVE),
    .V_ACTIVE  (V_ACTIVE),
    .DIV_WIDTH (DIV_WIDTH)
  ) com_m (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .x_in      (hcount_pipe[CONVERT_LATENCY-1]), // pipelined
    .y_in      (vcount_pipe[CONVERT_LATENCY-1]), // pipelined
    .valid_in  (valid_conv),
    .mask      (mask),
    .com       (com),
    .com_valid (com_valid)
  );

endmodule

`default_nettype wire

//--- verilog/center_of_mass.sv
`timescale 1ns/100ps
`default_nettype none

module center_of_mass import tracker_pkg::*; #(
  parameter int H_ACTIVE  = 320,
  parameter int V_ACTIVE  = 240,
  parameter int DIV_WIDTH = $bits(sum_t)
) (
  input  wire  clk_65mhz,
  input  wire  sys_rst,
  input  wire  hcount_t x_in,
  input  wire  vcount_t y_in,
  input  wire  valid_in,
  input  wire  mask,
  output com_t com,
  output logic com_valid
);

  typedef enum logic [1:0] {s_accumulate, s_dividing, s_report} com_state_t;

  com_state_t state;

  sum_t x_sum, y_sum, count;       // running frame totals
  sum_t x_sum_l, y_sum_l, count_l; // finished frame, held for the dividers
  sum_t quot_x, quot_y;
  logic div_start;
  logic done_x, done_y;
  logic frame_start;
  logic hit;

  // first pixel of a new frame closes the old one
  assign frame_start = valid_in && (x_in == '0) && (y_in == '0);
  // masked and inside the active window
  assign hit = mask && (x_in < H_ACTIVE) && (y_in < V_ACTIVE);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      x_sum <= '0;
      y_sum <= '0;
      count <= '0;
    end else if (frame_start) begin
      // restart with the new pixel counted
      x_sum <= hit ? sum_t'(x_in) : '0;
      y_sum <= hit ? sum_t'(y_in) : '0;
      count <= hit ? sum_t'(1) : '0;
    end else if (hit) begin
      x_sum <= x_sum + sum_t'(x_in);
      y_sum <= y_sum + sum_t'(y_in);
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state     <= s_accumulate;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      case (state)
        s_accumulate: if (frame_start && count != '0) begin
          x_sum_l   <= x_sum;  // old frame, before the clear
          y_sum_l   <= y_sum;
          count_l   <= count;
          div_start <= 1'b1;   // dividers load next edge
          state     <= s_dividing;
        end
        s_dividing: begin
          // boundaries here are dropped, accumulators still restart above
          // shared start and divisor, so both dones land together
          if (done_x && done_y) state <= s_report;
        end
        s_report: state <= s_accumulate; // single cycle
        default:  state <= s_accumulate;
      endcase
    end
  end

  // capture each quotient as it lands
  always_ff @(posedge clk_65mhz) begin
    if (done_x) com.x <= hcount_t'(quot_x);
    if (done_y) com.y <= vcount_t'(quot_y);
  end

  assign com_valid = (state == s_report); // one cycle after the later done

  serial_divider #(.DIV_WIDTH(DIV_WIDTH)) div_x (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (x_sum_l),
    .divisor   (count_l),
    .quotient  (quot_x),
    .done      (done_x)
  );

  serial_divider #(.DIV_WIDTH(DIV_WIDTH)) div_y (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (y_sum_l),
    .divisor   (count_l),
    .quotient  (quot_y),
    .done      (done_y)
  );

endmodule

`default_nettype wire

//--- verilog/serial_divider.sv
`timescale 1ns/100ps
`default_nettype none

module serial_divider import tracker_pkg::*; #(
  parameter int DIV_WIDTH = $bits(sum_t)
) (
  input  wire  clk_65mhz,
  input  wire  sys_rst,
  input  wire  start,
  input  wire  sum_t dividend,
  input  wire  sum_t divisor,
  output sum_t quotient,
  output logic done
);

  localparam int CNT_W = $clog2(DIV_WIDTH);

  typedef enum logic {div_idle, div_busy} div_state_t;

  div_state_t             state;
  logic [CNT_W-1:0]       bit_cnt;  // bits still to produce, minus one
  logic [DIV_WIDTH-1:0]   quot_r;   // dividend shifts out, quotient shifts in
  logic [DIV_WIDTH-1:0]   div_r;    // held divisor
  logic [DIV_WIDTH-1:0]   rem_r;    // partial remainder, always below div_r
  logic [DIV_WIDTH:0]     trial;    // remainder with next dividend bit

  assign trial = {rem_r, quot_r[DIV_WIDTH-1]};

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state   <= div_idle;
      done    <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0; // pulse only
      case (state)
        div_idle: if (start) begin
          state   <= div_busy;
          bit_cnt <= CNT_W'(DIV_WIDTH - 1);
          quot_r  <= dividend[DIV_WIDTH-1:0];
          div_r   <= divisor[DIV_WIDTH-1:0];
          rem_r   <= '0;
        end
        div_busy: begin
          // restoring step, keep remainder if the subtract would go negative
          if (trial >= {1'b0, div_r}) begin
            rem_r  <= DIV_WIDTH'(trial - {1'b0, div_r});
            quot_r <= {quot_r[DIV_WIDTH-2:0], 1'b1};
          end else begin
            rem_r  <= trial[DIV_WIDTH-1:0];
            quot_r <= {quot_r[DIV_WIDTH-2:0], 1'b0};
          end
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            state <= div_idle;
            done  <= 1'b1; // DIV_WIDTH+1 cycles after start
          end
        end
        default: state <= div_idle;
      endcase
    end
  end

  assign quotient = sum_t'(quot_r); // floor, held until the next start

endmodule

`default_nettype wire

//--- verilog/color_threshold.sv
`timescale 1ns/100ps
`default_nettype none

module color_threshold import tracker_pkg::*; (
  input  wire    ycrcb_t ycrcb_in,
  input  wire    rgb565_t rgb_in,
  input  wire    valid_in,
  input  wire    threshold_cfg_t cfg,
  output logic   mask
);

  nibble_t sel_nib; // top four bits of the chosen channel

  // channel mux, no register
  always_comb begin
    case (cfg.channel)
      sel_r:   sel_nib = rgb_in[15:12]; // top of the 5 bit red
      sel_g:   sel_nib = rgb_in[10:7];  // top of the 6 bit green
      sel_b:   sel_nib = rgb_in[4:1];
      sel_y:   sel_nib = ycrcb_in.y[7:4];
      sel_cr:  sel_nib = ycrcb_in.cr[7:4];
      sel_cb:  sel_nib = ycrcb_in.cb[7:4];
      default: sel_nib = 4'd0;           // unused codes match nothing useful
    endcase
  end

  // both bounds inclusive
  // invalid beats never mask
  assign mask = valid_in && (sel_nib >= cfg.lower) && (sel_nib <= cfg.upper);

endmodule

`default_nettype wire

//--- verilog/color_convert.sv
`timescale 1ns/100ps
`default_nettype none

module color_convert import tracker_pkg::*; (
  input  wire     clk_65mhz,
  input  wire     sys_rst,
  input  wire     rgb565_t rgb_in,
  input  wire     valid_in,
  output ycrcb_t  ycrcb_out,
  output rgb565_t rgb_out,
  output logic    valid_out
);

  // expand to 8 bits, top bits fill the gap
  chan_t r8, g8, b8;
  assign r8 = {rgb_in[15:11], rgb_in[15:13]};
  assign g8 = {rgb_in[10:5], rgb_in[10:9]};
  assign b8 = {rgb_in[4:0], rgb_in[4:2]};

  // stage 1 products, BT.601 coefficients x256
  logic [15:0] p_ry, p_gy, p_by;    // luma
  logic [15:0] p_rcb, p_gcb, p_bcb; // blue difference
  logic [15:0] p_rcr, p_gcr, p_bcr; // red difference

  // stage 2 sums, rounding constant folded in
  logic [17:0]        s_y;
  logic signed [17:0] s_cb, s_cr;

  // sideband travelling with the data
  rgb565_t rgb_pipe [CONVERT_LATENCY];
  logic    valid_pipe [CONVERT_LATENCY];

  // scale back, offset and clamp to the studio range
  function automatic chan_t clip_chan(input logic signed [17:0] v, input int lo, input int hi);
    logic signed [17:0] t;
    t = v;
    if (t < lo) t = 18'(lo);
    else if (t > hi) t = 18'(hi);
    return chan_t'(t[7:0]);
  endfunction

  always_ff @(posedge clk_65mhz) begin
    // multiply
    p_ry  <= 16'(r8 * 8'd66);
    p_gy  <= 16'(g8 * 8'd129);
    p_by  <= 16'(b8 * 8'd25);
    p_rcb <= 16'(r8 * 8'd38);
    p_gcb <= 16'(g8 * 8'd74);
    p_bcb <= 16'(b8 * 8'd112);
    p_rcr <= 16'(r8 * 8'd112);
    p_gcr <= 16'(g8 * 8'd94);
    p_bcr <= 16'(b8 * 8'd18);
    // sum
    s_y  <= {2'b00, p_ry} + {2'b00, p_gy} + {2'b00, p_by} + 18'd128;
    s_cb <= $signed({2'b00, p_bcb}) + 18'sd128 - $signed({2'b00, p_rcb})
            - $signed({2'b00, p_gcb});
    s_cr <= $signed({2'b00, p_rcr}) + 18'sd128 - $signed({2'b00, p_gcr})
            - $signed({2'b00, p_bcr});
    // offset and clip
    ycrcb_out.y  <= clip_chan($signed({8'd0, s_y[17:8]}) + 18'sd16, 16, 235);
    ycrcb_out.cb <= clip_chan((s_cb >>> 8) + 18'sd128, 16, 240);
    ycrcb_out.cr <= clip_chan((s_cr >>> 8) + 18'sd128, 16, 240);
  end

  // rgb rides along so R, G, B stay selectable
  always_ff @(posedge clk_65mhz) begin
    rgb_pipe[0] <= rgb_in;
    for (int i = 1; i < CONVERT_LATENCY; i++) begin
      rgb_pipe[i] <= rgb_pipe[i-1];
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < CONVERT_LATENCY; i++) begin
        valid_pipe[i] <= 1'b0;
      end
    end else begin
      valid_pipe[0] <= valid_in;
      for (int i = 1; i < CONVERT_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  assign rgb_out   = rgb_pipe[CONVERT_LATENCY-1];
  assign valid_out = valid_pipe[CONVERT_LATENCY-1]; // 3 cycles after valid_in

endmodule

`default_nettype wire

//--- verilog/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

  // pixel position and raw camera data
  typedef logic [10:0] hcount_t; // pixel on current line
  typedef logic [9:0]  vcount_t; // line number
  typedef logic [15:0] rgb565_t; // 5 red, 6 green, 5 blue

  typedef logic [7:0]  chan_t;   // one 8 bit component
  typedef logic [3:0]  nibble_t; // threshold intensity
  typedef logic [31:0] sum_t;    // accumulators and divider operands

  // one recovered camera pixel per beat
  typedef struct packed {
    logic    valid;
    hcount_t hcount;
    vcount_t vcount;
    rgb565_t rgb;
  } pixel_beat_t;

  typedef struct packed {
    chan_t y;
    chan_t cr;
    chan_t cb;
  } ycrcb_t;

  // which of the six channels feeds the threshold
  typedef enum logic [2:0] {
    sel_r  = 3'd0,
    sel_g  = 3'd1,
    sel_b  = 3'd2,
    sel_y  = 3'd3,
    sel_cr = 3'd4,
    sel_cb = 3'd5
  } channel_sel_t;

  typedef struct packed {
    channel_sel_t channel;
    nibble_t      lower; // inclusive
    nibble_t      upper; // inclusive
  } threshold_cfg_t;

  // centre of mass result
  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } com_t;

  localparam int CONVERT_LATENCY = 3; // color_convert register stages

endpackage

`default_nettype wire
